/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_rename_stage
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* commit_map.sv */
/*
 * Architectural map table updated at commit
 * Yields the stale physical registers that go back to the free list
 */
`timescale 1ns/1ps

module commit_map (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0] commit_i,
  output logic [rename_pkg::COMMIT_WIDTH-1:0]               free_valid_o,
  output rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]  free_preg_o,
  output logic [1:0]                                        commit_alloc_cnt_o,
  output rename_pkg::preg_t [rename_pkg::AREG_NUM-1:0]      arch_map_o
);

  // Committed table and its next state
  rename_pkg::preg_t [rename_pkg::AREG_NUM-1:0] arch_tab;
  rename_pkg::preg_t [rename_pkg::AREG_NUM-1:0] arch_next;

  // Lanes that retire a destination
  logic [rename_pkg::COMMIT_WIDTH-1:0] lane_free;

  // ========================================
  // Commit walk
  // ========================================
  always_comb begin
    arch_next          = arch_tab;
    commit_alloc_cnt_o = 2'd0;
    for (int i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin
      lane_free[i]   = commit_i[i].valid && commit_i[i].has_rd;
      free_preg_o[i] = '0;
      if (lane_free[i]) begin
        // Read the partly updated table, so a repeated ard frees the older lane's prd
        free_preg_o[i]              = arch_next[commit_i[i].ard];
        arch_next[commit_i[i].ard]  = commit_i[i].prd;
        commit_alloc_cnt_o          = commit_alloc_cnt_o + 1'b1;
      end
    end
  end

  assign free_valid_o = lane_free;

  // Next-state view, keeps a flush in a commit cycle consistent
  assign arch_map_o = arch_next;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity mapping
      for (int a = 0; a < rename_pkg::AREG_NUM; a++) begin
        arch_tab[a] <= rename_pkg::preg_t'(a);
      end
    end else begin
      arch_tab <= arch_next;
    end
  end

endmodule

/* free_list.sv */
/*
 * Circular free list of physical registers
 * Speculative head for allocation, committed head and count for flush recovery
 */
`timescale 1ns/1ps

module free_list (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              flush_i,
  input  logic [rename_pkg::DECODE_WIDTH-1:0]               alloc_valid_i,
  output logic                                              alloc_ready_o,
  output rename_pkg::preg_t [rename_pkg::DECODE_WIDTH-1:0]  alloc_preg_o,
  input  logic [rename_pkg::COMMIT_WIDTH-1:0]               free_valid_i,
  input  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0]  free_preg_i,
  input  logic [1:0]                                        commit_alloc_cnt_i
);

  // Ring storage, one physical register per slot
  rename_pkg::preg_t ring [rename_pkg::PREG_NUM];

  // Speculative state
  rename_pkg::preg_t                 head;
  rename_pkg::preg_t                 tail;
  logic [rename_pkg::CNT_W-1:0]      count;
  // Committed copies
  rename_pkg::preg_t                 commit_head;
  logic [rename_pkg::CNT_W-1:0]      commit_cnt;

  // Pointer walk results
  rename_pkg::preg_t                 rd_ptr;
  rename_pkg::preg_t                 wr_ptr;
  rename_pkg::preg_t                 wr_idx [rename_pkg::COMMIT_WIDTH];
  logic [1:0]                        alloc_num;
  logic [1:0]                        free_num;
  logic [rename_pkg::CNT_W-1:0]      count_n;
  rename_pkg::preg_t                 commit_head_n;
  logic [rename_pkg::CNT_W-1:0]      commit_cnt_n;

  // Need room for a full group, none during flush
  assign alloc_ready_o = (count >= rename_pkg::CNT_W'(rename_pkg::DECODE_WIDTH)) && !flush_i;

  // ========================================
  // Read side
  // ========================================
  always_comb begin
    rd_ptr    = head;
    alloc_num = 2'd0;
    for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
      // Lanes without a destination skip the slot
      alloc_preg_o[i] = ring[rd_ptr];
      if (alloc_valid_i[i]) begin
        rd_ptr    = rd_ptr + 1'b1;
        alloc_num = alloc_num + 1'b1;
      end
    end
  end

  // ========================================
  // Write side
  // ========================================
  always_comb begin
    wr_ptr   = tail;
    free_num = 2'd0;
    for (int i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin
      wr_idx[i] = wr_ptr;
      if (free_valid_i[i]) begin
        wr_ptr   = wr_ptr + 1'b1;
        free_num = free_num + 1'b1;
      end
    end
  end

  // Occupancy updates
  assign count_n       = count + rename_pkg::CNT_W'(free_num) - rename_pkg::CNT_W'(alloc_num);
  assign commit_head_n = commit_head + rename_pkg::PREG_W'(commit_alloc_cnt_i);
  assign commit_cnt_n  = commit_cnt + rename_pkg::CNT_W'(free_num)
                       - rename_pkg::CNT_W'(commit_alloc_cnt_i);

  // Ring contents, slot i starts with register i+32
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < rename_pkg::PREG_NUM; i++) begin
        ring[i] <= rename_pkg::preg_t'(i + rename_pkg::AREG_NUM);
      end
    end else begin
      for (int i = 0; i < rename_pkg::COMMIT_WIDTH; i++) begin
        if (free_valid_i[i]) begin
          ring[wr_idx[i]] <= free_preg_i[i];
        end
      end
    end
  end

  // Pointers and counts
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head        <= '0;
      tail        <= rename_pkg::preg_t'(rename_pkg::AREG_NUM);
      count       <= rename_pkg::CNT_W'(rename_pkg::PREG_NUM - rename_pkg::AREG_NUM);
      commit_head <= '0;
      commit_cnt  <= rename_pkg::CNT_W'(rename_pkg::PREG_NUM - rename_pkg::AREG_NUM);
    end else begin
      // Frees land regardless of flush
      tail        <= wr_ptr;
      commit_head <= commit_head_n;
      commit_cnt  <= commit_cnt_n;
      if (flush_i) begin
        // Roll back to committed state including this cycle's commits
        head  <= commit_head_n;
        count <= commit_cnt_n;
      end else begin
        head  <= rd_ptr;
        count <= count_n;
      end
    end
  end

endmodule

/* rename_map.sv */
/*
 * Speculative register alias table
 * Source and old-destination lookup with in-group bypass, restored on flush
 */
`timescale 1ns/1ps

module rename_map (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic                                                    flush_i,
  input  rename_pkg::rename_req_t [rename_pkg::DECODE_WIDTH-1:0]  req_i,
  input  logic                                                    accept_i,
  input  rename_pkg::preg_t [rename_pkg::DECODE_WIDTH-1:0]        alloc_preg_i,
  input  rename_pkg::preg_t [rename_pkg::AREG_NUM-1:0]            arch_map_i,
  output rename_pkg::rename_rsp_t [rename_pkg::DECODE_WIDTH-1:0]  rsp_o
);

  // Speculative table, indexed by architectural register
  rename_pkg::preg_t spec_map [rename_pkg::AREG_NUM];

  // Lanes that write a destination
  logic [rename_pkg::DECODE_WIDTH-1:0] lane_wr;

  always_comb begin
    for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
      lane_wr[i] = req_i[i].valid && req_i[i].has_rd;
    end
  end

  // ========================================
  // Lookup with in-group bypass
  // ========================================
  always_comb begin
    for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
      // Table values first
      rsp_o[i].prs1    = spec_map[req_i[i].rs1];
      rsp_o[i].prs2    = spec_map[req_i[i].rs2];
      rsp_o[i].old_prd = spec_map[req_i[i].rd];
      rsp_o[i].prd     = lane_wr[i] ? alloc_preg_i[i] : '0;
      // Older lanes in the group override, youngest older lane last
      for (int j = 0; j < i; j++) begin
        if (lane_wr[j]) begin
          if (req_i[j].rd == req_i[i].rs1) begin
            rsp_o[i].prs1 = alloc_preg_i[j];
          end
          if (req_i[j].rd == req_i[i].rs2) begin
            rsp_o[i].prs2 = alloc_preg_i[j];
          end
          // Same rd twice, old mapping is the older lane's new one
          if (req_i[j].rd == req_i[i].rd) begin
            rsp_o[i].old_prd = alloc_preg_i[j];
          end
        end
      end
    end
  end

  // ========================================
  // Table update
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity mapping
      for (int a = 0; a < rename_pkg::AREG_NUM; a++) begin
        spec_map[a] <= rename_pkg::preg_t'(a);
      end
    end else if (flush_i) begin
      // Take committed table after this cycle's commits
      for (int a = 0; a < rename_pkg::AREG_NUM; a++) begin
        spec_map[a] <= arch_map_i[a];
      end
    end else if (accept_i) begin
      // Ascending order so lane 1 wins on same rd
      for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
        if (lane_wr[i]) begin
          spec_map[req_i[i].rd] <= alloc_preg_i[i];
        end
      end
    end
  end

endmodule

/* rename_pkg.sv */
/*
 * Shared widths, lane counts and lane structs for the register-rename block
 */
package rename_pkg;

  // ========================================
  // Sizes
  // ========================================

  // Lanes renamed per cycle
  localparam int DECODE_WIDTH = 2;
  // Lanes retired per cycle
  localparam int COMMIT_WIDTH = 2;

  // Physical register count, power of two so ring pointers wrap for free
  localparam int PREG_NUM = 64;
  localparam int AREG_NUM = 32;

  localparam int PREG_W = 6;
  localparam int AREG_W = 5;
  // Occupancy count, holds 0 to PREG_NUM
  localparam int CNT_W = 7;

  // ========================================
  // Types
  // ========================================

  typedef logic [PREG_W-1:0] preg_t;
  typedef logic [AREG_W-1:0] areg_t;

  // One decoded lane into rename
  typedef struct packed {
    logic  valid;
    logic  has_rd;
    areg_t rd;
    areg_t rs1;
    areg_t rs2;
  } rename_req_t;

  // One renamed lane out
  typedef struct packed {
    preg_t prd;
    preg_t prs1;
    preg_t prs2;
    // Previous mapping of rd, freed when this instruction retires
    preg_t old_prd;
  } rename_rsp_t;

  // One retiring instruction
  typedef struct packed {
    logic  valid;
    logic  has_rd;
    areg_t ard;
    preg_t prd;
  } commit_t;

endpackage

/* rename_props.sv */
/*
 * Concurrent checks on the rename stage, bound into rename_stage
 */
`timescale 1ns/1ps

module rename_props (
  input logic                                                   clk,
  input logic                                                   rst_n,
  input logic                                                   ready_i,
  input logic [rename_pkg::CNT_W-1:0]                           free_cnt_i,
  input rename_pkg::rename_req_t [rename_pkg::DECODE_WIDTH-1:0] req_i
);

  // Back-pressure holds the ring, no register leaves while ready is low
  a_ready_room: assert property (@(posedge clk) disable iff (!rst_n)
    !ready_i |=> (free_cnt_i >= $past(free_cnt_i)))
    else $error("register allocated while rename ready was low");

  // Ring never holds more than every physical register
  a_cnt_max: assert property (@(posedge clk) disable iff (!rst_n)
    free_cnt_i <= rename_pkg::CNT_W'(rename_pkg::PREG_NUM))
    else $error("free count above the number of physical registers");

  // Valid lanes packed from lane 0
  for (genvar i = 1; i < rename_pkg::DECODE_WIDTH; i++) begin : g_contig
    a_lanes_contig: assert property (@(posedge clk) disable iff (!rst_n)
      req_i[i].valid |-> req_i[i-1].valid)
      else $error("rename lane valid without the lane below it");
  end

endmodule

bind rename_stage rename_props u_rename_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .ready_i    (rename_ready_o),
  .free_cnt_i (u_free_list.count),
  .req_i      (req_i)
);

/* rename_stage.sv */
/*
 * Register-rename stage, two lanes in and two commits per cycle
 */
`timescale 1ns/1ps

module rename_stage (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic                                                    flush_i,
  input  rename_pkg::rename_req_t [rename_pkg::DECODE_WIDTH-1:0]  req_i,
  input  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0]      commit_i,
  output logic                                                    rename_ready_o,
  output rename_pkg::rename_rsp_t [rename_pkg::DECODE_WIDTH-1:0]  rsp_o
);

  // ========================================
  // Internal nets
  // ========================================
  logic                                          alloc_ready;
  logic [rename_pkg::DECODE_WIDTH-1:0]           alloc_valid;
  logic                                          accept;
  rename_pkg::preg_t [rename_pkg::DECODE_WIDTH-1:0] alloc_preg;
  logic [rename_pkg::COMMIT_WIDTH-1:0]           free_valid;
  rename_pkg::preg_t [rename_pkg::COMMIT_WIDTH-1:0] free_preg;
  logic [1:0]                                    commit_alloc_cnt;
  rename_pkg::preg_t [rename_pkg::AREG_NUM-1:0]  arch_map;

  // Lane masking, allocate only on accepted lanes with a destination
  always_comb begin
    accept = 1'b0;
    for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
      alloc_valid[i] = alloc_ready && req_i[i].valid && req_i[i].has_rd;
      accept         = accept || req_i[i].valid;
    end
    // Group taken when any lane valid and ready
    accept = accept && alloc_ready;
  end

  assign rename_ready_o = alloc_ready;

  free_list u_free_list (
    .clk                (clk),
    .rst_n              (rst_n),
    .flush_i            (flush_i),
    .alloc_valid_i      (alloc_valid),
    .alloc_ready_o      (alloc_ready),
    .alloc_preg_o       (alloc_preg),
    .free_valid_i       (free_valid),
    .free_preg_i        (free_preg),
    .commit_alloc_cnt_i (commit_alloc_cnt)
  );

  rename_map u_rename_map (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .req_i        (req_i),
    .accept_i     (accept),
    .alloc_preg_i (alloc_preg),
    .arch_map_i   (arch_map),
    .rsp_o        (rsp_o)
  );

  commit_map u_commit_map (
    .clk                (clk),
    .rst_n              (rst_n),
    .commit_i           (commit_i),
    .free_valid_o       (free_valid),
    .free_preg_o        (free_preg),
    .commit_alloc_cnt_o (commit_alloc_cnt),
    .arch_map_o         (arch_map)
  );

endmodule

/* rename_tb.sv */
/*
 * Testbench for the rename stage
 * Table-driven stimulus checked against a model of the maps and the free ring
 */
`timescale 1ns/1ps

module tb_rename_stage;

  // One table row, commits retire the oldest renamed instructions
  typedef struct packed {
    rename_pkg::rename_req_t r0;
    rename_pkg::rename_req_t r1;
    logic [1:0]              ncommit;
    logic                    flush;
  } stim_t;

  logic clk = 1'b0;
  logic rst_n;
  logic flush_i;
  logic ready;
  rename_pkg::rename_req_t [rename_pkg::DECODE_WIDTH-1:0] req;
  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0]     cmt;
  rename_pkg::rename_rsp_t [rename_pkg::DECODE_WIDTH-1:0] rsp;

  stim_t  stim_q[$];
  string  stim_name[$];
  logic   table_built = 1'b0;
  integer seed = 32'heca3_9fe0;

  // Model state, maps plus free ring with speculative and committed heads
  rename_pkg::preg_t   m_spec [rename_pkg::AREG_NUM];
  rename_pkg::preg_t   m_arch [rename_pkg::AREG_NUM];
  rename_pkg::preg_t   m_ring [rename_pkg::PREG_NUM];
  rename_pkg::preg_t   m_head, m_tail, m_chead;
  int                  m_count, m_ccount;
  rename_pkg::commit_t pend_q[$];

  // Row in flight and counters
  stim_t                                              cur;
  rename_pkg::commit_t [rename_pkg::COMMIT_WIDTH-1:0] cur_cmt;
  string cur_name;
  int    errors, test_errs, checks, tests_pass, tests_fail;

  rename_stage u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .flush_i        (flush_i),
    .req_i          (req),
    .commit_i       (cmt),
    .rename_ready_o (ready),
    .rsp_o          (rsp)
  );

  always #10 clk = ~clk;

  function automatic rename_pkg::rename_req_t make_req(logic v, logic h, int rd, int rs1, int rs2);
    rename_pkg::rename_req_t r;
    r.valid  = v;
    r.has_rd = h;
    r.rd     = rename_pkg::areg_t'(rd);
    r.rs1    = rename_pkg::areg_t'(rs1);
    r.rs2    = rename_pkg::areg_t'(rs2);
    return r;
  endfunction

  task automatic add_stim(string name, rename_pkg::rename_req_t r0, rename_pkg::rename_req_t r1,
                          int ncommit, logic flush);
    stim_t s;
    s.r0      = r0;
    s.r1      = r1;
    s.ncommit = 2'(ncommit);
    s.flush   = flush;
    stim_q.push_back(s);
    stim_name.push_back(name);
  endtask

  // ========================================
  // Stimulus table
  // ========================================
  task automatic build_table();
    rename_pkg::rename_req_t idle;
    int v0;
    int v1;
    idle = '0;
    add_stim("reset_alloc", make_req(1, 1, 1, 10, 11), make_req(1, 1, 2, 12, 13), 0, 0);
    add_stim("reset_alloc", make_req(1, 1, 3, 14, 15), make_req(1, 1, 4, 16, 17), 0, 0);
    // Lane 1 without rd, odd total so ready drops at one free
    add_stim("reset_alloc", make_req(1, 1, 5, 18, 19), make_req(1, 0, 6, 20, 21), 0, 0);
    add_stim("bypass", make_req(1, 1, 7, 1, 2), make_req(1, 1, 9, 7, 7), 0, 0);
    add_stim("same_rd", make_req(1, 1, 8, 8, 3), make_req(1, 1, 8, 8, 8), 0, 0);
    for (int k = 0; k < 12; k++) begin
      add_stim("fill", make_req(1, 1, 10 + k % 8, k, k + 1),
               make_req(1, 1, 20 + k % 8, 10 + k % 8, 3), 0, 0);
    end
    add_stim("stall", make_req(1, 1, 30, 1, 2), make_req(1, 1, 31, 3, 4), 0, 0);
    add_stim("stall", make_req(1, 1, 29, 5, 6), make_req(1, 0, 28, 7, 8), 0, 0);
    for (int k = 0; k < 5; k++) begin
      add_stim("commit_free", idle, idle, 2, 0);
    end
    for (int k = 0; k < 3; k++) begin
      add_stim("realloc", make_req(1, 1, 11, 1, 2), make_req(1, 1, 12, 3, 4), 0, 0);
    end
    add_stim("flush", idle, idle, 1, 1);
    add_stim("after_flush", make_req(1, 1, 13, 1, 7), make_req(1, 1, 14, 8, 13), 0, 0);
    add_stim("after_flush", make_req(1, 1, 15, 11, 12), make_req(1, 1, 16, 15, 2), 0, 0);
    // Narrow register range so in-group hits are common
    for (int k = 0; k < 200; k++) begin
      v0 = $random(seed);
      v1 = $random(seed);
      add_stim("random_mix",
               make_req((v0 & 3) != 0, (v0 & 12) != 0, (v0 >> 4) & 15, (v0 >> 8) & 15,
                        (v0 >> 12) & 15),
               make_req((v0 & 3) != 0 && (v1 & 1) != 0, (v1 & 6) != 0, (v1 >> 4) & 15,
                        (v1 >> 8) & 15, (v1 >> 12) & 15),
               (v1 >> 20) & 3, ((v1 >> 24) & 31) == 0);
    end
  endtask

  task automatic model_reset();
    for (int a = 0; a < rename_pkg::AREG_NUM; a++) begin
      m_spec[a] = rename_pkg::preg_t'(a);
      m_arch[a] = rename_pkg::preg_t'(a);
    end
    for (int i = 0; i < rename_pkg::PREG_NUM; i++) begin
      m_ring[i] = rename_pkg::preg_t'(i + rename_pkg::AREG_NUM);
    end
    m_head   = '0;
    m_chead  = '0;
    m_tail   = rename_pkg::preg_t'(rename_pkg::AREG_NUM);
    m_count  = rename_pkg::PREG_NUM - rename_pkg::AREG_NUM;
    m_ccount = m_count;
  endtask

  task automatic check_value(string what, int exp, int act);
    checks++;
    assert (exp == act) else begin
      $display("Fail %s %s: expected %0d actual %0d", cur_name, what, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  task automatic report_test(string name);
    if (test_errs == 0) begin
      $display("Test %s: ok", name);
      tests_pass++;
    end else begin
      $display("Test %s: %0d errors", name, test_errs);
      tests_fail++;
    end
    test_errs = 0;
  endtask

  // Drive one row, commits popped from the oldest pending renames
  task automatic apply_entry(int idx);
    int n;
    cur      = stim_q[idx];
    cur_name = stim_name[idx];
    n        = int'(cur.ncommit);
    cur_cmt  = '0;
    for (int k = 0; k < rename_pkg::COMMIT_WIDTH; k++) begin
      if (k < n && pend_q.size() > 0) begin
        cur_cmt[k] = pend_q.pop_front();
      end
    end
    req[0]  <= cur.r0;
    req[1]  <= cur.r1;
    cmt     <= cur_cmt;
    flush_i <= cur.flush;
  endtask

  // ========================================
  // Expected values, then model update
  // ========================================
  task automatic check_and_advance();
    rename_pkg::rename_req_t r [rename_pkg::DECODE_WIDTH];
    rename_pkg::preg_t       new_prd [rename_pkg::DECODE_WIDTH];
    rename_pkg::preg_t       e_prs1, e_prs2, e_old, stale, ptr;
    rename_pkg::commit_t     p;
    logic                    exp_ready, accept, wr0;
    r[0]      = cur.r0;
    r[1]      = cur.r1;
    exp_ready = (m_count >= rename_pkg::DECODE_WIDTH) && !cur.flush;
    check_value("ready", int'(exp_ready), int'(ready));
    accept     = exp_ready && (r[0].valid || r[1].valid);
    wr0        = r[0].valid && r[0].has_rd;
    ptr        = m_head;
    new_prd[0] = '0;
    new_prd[1] = '0;
    for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
      if (accept && r[i].valid) begin
        e_prs1 = m_spec[r[i].rs1];
        e_prs2 = m_spec[r[i].rs2];
        e_old  = m_spec[r[i].rd];
        // Lane 1 sees lane 0's new destination
        if (i == 1 && wr0) begin
          e_prs1 = (r[0].rd == r[1].rs1) ? new_prd[0] : e_prs1;
          e_prs2 = (r[0].rd == r[1].rs2) ? new_prd[0] : e_prs2;
          e_old  = (r[0].rd == r[1].rd) ? new_prd[0] : e_old;
        end
        check_value($sformatf("prs1[%0d]", i), int'(e_prs1), int'(rsp[i].prs1));
        check_value($sformatf("prs2[%0d]", i), int'(e_prs2), int'(rsp[i].prs2));
        if (r[i].has_rd) begin
          new_prd[i] = m_ring[ptr];
          ptr        = ptr + 1'b1;
          m_count--;
          check_value($sformatf("prd[%0d]", i), int'(new_prd[i]), int'(rsp[i].prd));
          check_value($sformatf("old_prd[%0d]", i), int'(e_old), int'(rsp[i].old_prd));
        end
        p = {1'b1, r[i].has_rd, r[i].rd, new_prd[i]};
        pend_q.push_back(p);
      end
    end
    // Table writes after all lookups, lane 1 last so it wins on the same rd
    for (int i = 0; i < rename_pkg::DECODE_WIDTH; i++) begin
      if (accept && r[i].valid && r[i].has_rd) begin
        m_spec[r[i].rd] = new_prd[i];
      end
    end
    m_head = ptr;
    // Commit frees the previous committed mapping of ard
    for (int k = 0; k < rename_pkg::COMMIT_WIDTH; k++) begin
      if (cur_cmt[k].valid && cur_cmt[k].has_rd) begin
        stale                  = m_arch[cur_cmt[k].ard];
        m_arch[cur_cmt[k].ard] = cur_cmt[k].prd;
        m_ring[m_tail]         = stale;
        m_tail                 = m_tail + 1'b1;
        m_chead                = m_chead + 1'b1;
        m_count++;
      end
    end
    // Back to committed state, younger renames squashed
    if (cur.flush) begin
      m_spec  = m_arch;
      m_head  = m_chead;
      m_count = m_ccount;
      pend_q.delete();
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    req        = '0;
    cmt        = '0;
    errors     = 0;
    test_errs  = 0;
    checks     = 0;
    tests_pass = 0;
    tests_fail = 0;
    model_reset();
    build_table();
    table_built = 1'b1;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < stim_q.size(); i++) begin
      @(posedge clk);
      if (i > 0 && stim_name[i] != stim_name[i-1]) begin
        report_test(stim_name[i-1]);
      end
      apply_entry(i);
      @(negedge clk);
      check_and_advance();
    end
    @(posedge clk);
    req     <= '0;
    cmt     <= '0;
    flush_i <= 1'b0;
    report_test(stim_name[stim_q.size()-1]);
    $display("Tests ok %0d, with errors %0d, checks %0d, errors %0d",
             tests_pass, tests_fail, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Two clock periods per row plus margin for reset
  initial begin
    wait (table_built);
    #(stim_q.size() * 40 + 1000);
    $display("Timeout: the stimulus table did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

/* sim.f */
rename_pkg.sv
free_list.sv
rename_map.sv
commit_map.sv
rename_stage.sv
rename_props.sv
rename_tb.sv
